// File: Bender.yml
package:
  name: nyquist

sources:
  - verilog/conv_pkg.sv
  - verilog/noise_pkg.sv
  - verilog/spi_clock_gen.sv
  - verilog/lfsr_noise.sv
  - verilog/adc_preamp_driver.sv
  - verilog/dac_driver.sv
  - verilog/nyquist_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/nyquist_tb.sv

// File: compile.f
verilog/conv_pkg.sv
verilog/noise_pkg.sv
verilog/spi_clock_gen.sv
verilog/lfsr_noise.sv
verilog/adc_preamp_driver.sv
verilog/dac_driver.sv
verilog/nyquist_top.sv
verif/tb_clock.sv
verif/nyquist_tb.sv

// File: verif/nyquist_tb.sv
module nyquist_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam noise_pkg::lfsr_state_t SEED = 31'b1001001011011010111100101000100;
  localparam logic [7:0] GAIN = 8'h11;
  localparam int MODEL_LEN = 512;

  logic       clk_50m;
  logic       rst;
  logic [3:0] sw;
  logic       adc_out;
  logic       dac_cs;
  logic       dac_clr;
  logic       spi_sck;
  logic       amp_cs;
  logic       spi_mosi;
  logic [7:0] led;
  logic       ad_conv;

  // edge flags of the current cycle are updated at each falling clk edge
  logic sck_last = 1'b0;
  logic sck_rise = 1'b0;
  logic sck_fall = 1'b0;
  logic conv_seen = 1'b0;

  logic [31:0] rng = 32'h4176;
  logic [13:0] cur_va = '0;
  logic [13:0] cur_vb = '0;
  logic [13:0] last_done_va = '0;
  logic [33:0] adc_frame = '0;
  int          adc_idx = 34;
  int          adc_rises = 34;

  logic        amp_last = 1'b1;
  logic [7:0]  amp_bits;
  int          amp_count;
  int          amp_windows = 0;
  logic        dac_last = 1'b1;
  logic [31:0] dac_bits;
  int          dac_count;
  logic        chan_b_next = 1'b0;
  int          b_frames = 0;
  logic [11:0] b_expect [$];
  logic [11:0] a_values [$];

  int          led_mode = 0;
  int          led_idx = 0;
  int          led_j;
  logic [11:0] seed_word;

  noise_pkg::lfsr_state_t model_states [MODEL_LEN];

  tb_clock u_clk (
    .clk_50m (clk_50m),
    .rst     (rst)
  );

  nyquist_top #(
    .LFSR_SEED (SEED),
    .GAIN      (GAIN)
  ) dut (
    .clk_50m  (clk_50m),
    .rst      (rst),
    .sw       (sw),
    .adc_out  (adc_out),
    .dac_cs   (dac_cs),
    .dac_clr  (dac_clr),
    .spi_sck  (spi_sck),
    .amp_cs   (amp_cs),
    .spi_mosi (spi_mosi),
    .led      (led),
    .ad_conv  (ad_conv)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic noise_pkg::lfsr_state_t lfsr_next(input noise_pkg::lfsr_state_t s);
    logic fb;
    fb = ~(s[noise_pkg::TAP_HI] ^ s[noise_pkg::TAP_LO]);
    return {s[noise_pkg::LFSR_WIDTH-2:0], fb};
  endfunction

  // the first picked state bit ends up as the msb of the noise word
  function automatic logic [11:0] noise_of(input noise_pkg::lfsr_state_t s);
    logic [11:0] w;
    w = '0;
    for (int i = 0; i < 12; i++) begin
      w = {w[10:0], s[noise_pkg::NOISE_PICK[i]]};
    end
    return w;
  endfunction

  function automatic int find_state(input int from, input logic [11:0] value,
                                    input logic [11:0] mask);
    for (int k = from; k < MODEL_LEN; k++) begin
      if ((noise_of(model_states[k]) & mask) == (value & mask)) begin
        return k;
      end
    end
    return -1;
  endfunction

  function automatic logic [11:0] to_offset12(input logic [13:0] va);
    return {~va[13], va[12:2]};
  endfunction

  initial begin
    model_states[0] = SEED;
    for (int k = 1; k < MODEL_LEN; k++) begin
      model_states[k] = lfsr_next(model_states[k-1]);
    end
    seed_word = noise_of(SEED);
  end

  // the adc model returns 2 idle bits, va, 2 idle bits, vb and 2 idle bits
  initial begin
    adc_out = 1'b0;
    forever begin
      @(posedge clk_50m);
      if (conv_seen) begin
        rng = xorshift32(rng);
        cur_va = rng[13:0];
        cur_vb = rng[27:14];
        adc_frame = {2'b00, cur_va, 2'b00, cur_vb, 2'b00};
        adc_idx = 1;
        adc_rises = 0;
        adc_out <= adc_frame[33];
      end else if (sck_fall && adc_idx < 34) begin
        adc_out <= adc_frame[33-adc_idx];
        adc_idx++;
      end else if (sck_fall) begin
        adc_out <= 1'b0;
      end
      if (sck_rise && adc_rises < 34) begin
        adc_rises++;
        if (adc_rises == 34) begin
          last_done_va = cur_va;
        end
      end
    end
  end

  task automatic close_amp_window();
    amp_windows++;
    assert (amp_windows == 1) else abort_run("a second preamp chip select window occurred");
    assert (amp_count == 8) else
      abort_run($sformatf("ERROR: amp_cs window bits expected %h got %h", 8, amp_count));
    assert (amp_bits == GAIN) else
      abort_run($sformatf("ERROR: spi_mosi gain expected %h got %h", GAIN, amp_bits));
  endtask

  task automatic close_dac_frame();
    logic [3:0]  exp_addr;
    logic [11:0] data;
    logic [11:0] exp_b;
    exp_addr = chan_b_next ? 4'h1 : 4'h0;
    data = dac_bits[15:4];
    assert (dac_count == 32) else
      abort_run($sformatf("ERROR: dac_cs window bits expected %h got %h", 32, dac_count));
    assert (dac_bits[23:20] == 4'b0011) else
      abort_run($sformatf("ERROR: spi_mosi command expected %h got %h", 4'b0011,
                          dac_bits[23:20]));
    assert (dac_bits[19:16] == exp_addr) else
      abort_run($sformatf("ERROR: spi_mosi address expected %h got %h", exp_addr,
                          dac_bits[19:16]));
    if (!chan_b_next) begin
      a_values.push_back(data);
    end else begin
      exp_b = b_expect.pop_front();
      assert (data == exp_b) else
        abort_run($sformatf("ERROR: spi_mosi channel b expected %h got %h", exp_b, data));
      b_frames++;
    end
    chan_b_next = !chan_b_next;
  endtask

  always @(negedge clk_50m) begin
    if (rst !== 1'b0) begin
      sck_rise = 1'b0;
      sck_fall = 1'b0;
      conv_seen = 1'b0;
      sck_last = 1'b0;
    end else begin
      sck_rise = spi_sck && !sck_last;
      sck_fall = !spi_sck && sck_last;
      sck_last = spi_sck;
      conv_seen = (ad_conv === 1'b1);
      assert (dac_clr === 1'b1) else
        abort_run($sformatf("ERROR: dac_clr expected %h got %h", 1'b1, dac_clr));
      if (!amp_cs && amp_last) begin
        amp_bits = '0;
        amp_count = 0;
      end
      if (!amp_cs && sck_rise) begin
        amp_bits = {amp_bits[6:0], spi_mosi};
        amp_count++;
      end
      if (amp_cs && !amp_last) begin
        close_amp_window();
      end
      amp_last = amp_cs;
      // the value channel b will carry is fixed when channel a opens
      if (!dac_cs && dac_last) begin
        dac_bits = '0;
        dac_count = 0;
        if (!chan_b_next) begin
          b_expect.push_back(to_offset12(last_done_va));
        end
      end
      if (!dac_cs && sck_rise) begin
        dac_bits = {dac_bits[30:0], spi_mosi};
        dac_count++;
      end
      if (dac_cs && !dac_last) begin
        close_dac_frame();
      end
      dac_last = dac_cs;
      if (led_mode == 1) begin
        assert (led == seed_word[7:0]) else
          abort_run($sformatf("ERROR: led expected %h got %h", seed_word[7:0], led));
      end else if (led_mode == 2) begin
        led_j = find_state(led_idx, {4'h0, led}, 12'h0ff);
        assert (led_j >= 0) else
          abort_run($sformatf("ERROR: led value %h matches no model state from index %h",
                              led, led_idx));
        led_idx = led_j;
      end
    end
  end

  task automatic wait_b_frames(input int target, input int limit);
    int n;
    n = 0;
    while (b_frames < target && n < limit) begin
      @(negedge clk_50m);
      n++;
    end
    assert (b_frames >= target) else
      abort_run("timed out waiting for dac channel b frames");
  endtask

  task automatic reset_levels();
    int n;
    repeat (2) @(negedge clk_50m);
    assert (dac_cs === 1'b1 && dac_clr === 1'b1 && amp_cs === 1'b1 && ad_conv === 1'b0 &&
            spi_sck === 1'b0) else
      abort_run($sformatf(
        "ERROR: dac_cs dac_clr amp_cs ad_conv spi_sck in reset got %h %h %h %h %h",
        dac_cs, dac_clr, amp_cs, ad_conv, spi_sck));
    n = 0;
    while (rst !== 1'b0 && n < 50) begin
      @(negedge clk_50m);
      n++;
    end
    assert (rst === 1'b0) else abort_run("reset was never released");
    assert (dac_cs === 1'b1 && dac_clr === 1'b1 && amp_cs === 1'b1 && ad_conv === 1'b0 &&
            spi_sck === 1'b0) else
      abort_run($sformatf(
        "ERROR: dac_cs dac_clr amp_cs ad_conv spi_sck after reset got %h %h %h %h %h",
        dac_cs, dac_clr, amp_cs, ad_conv, spi_sck));
  endtask

  task automatic preamp_load();
    int n;
    n = 0;
    while (amp_windows < 1 && n < 1000) begin
      @(negedge clk_50m);
      n++;
    end
    assert (amp_windows == 1) else abort_run("timed out waiting for the preamp gain load");
  endtask

  task automatic noise_held();
    logic [11:0] a;
    led_mode = 1;
    wait_b_frames(3, 5000);
    while (a_values.size() > 0) begin
      a = a_values.pop_front();
      assert (a == noise_of(SEED)) else
        abort_run($sformatf("ERROR: channel a expected %h got %h", noise_of(SEED), a));
    end
  endtask

  task automatic noise_running();
    logic [11:0] a;
    int          a_idx;
    int          j;
    a_idx = 0;
    @(posedge clk_50m);
    sw <= 4'b0001;
    led_mode = 2;
    wait_b_frames(b_frames + 6, 20000);
    while (a_values.size() > 0) begin
      a = a_values.pop_front();
      j = find_state(a_idx, a, 12'hfff);
      assert (j >= 0) else
        abort_run($sformatf("ERROR: channel a value %h matches no model state from index %h",
                            a, a_idx));
      a_idx = j;
    end
    assert (a_idx > 0) else abort_run("channel a never left the seed word while running");
    assert (led_idx > 0) else abort_run("led never left the seed byte while running");
  endtask

  initial begin
    sw = 4'b0000;
    reset_levels();
    preamp_load();
    noise_held();
    noise_running();
    $display("Test passed");
    $finish;
  end

endmodule

// File: verif/tb_clock.sv
module tb_clock #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_50m,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_50m = 1'b0;
    forever #HALF_PERIOD clk_50m = ~clk_50m;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_50m);
    rst <= 1'b0;
  end

endmodule

// File: verilog/adc_preamp_driver.sv
module adc_preamp_driver #(
  parameter logic [conv_pkg::GAIN_BITS-1:0] GAIN = 8'h11
) (
  input  logic                  clk_50m,
  input  logic                  rst,
  input  conv_pkg::spi_clk_t    sck_bus,
  input  logic                  adc_out,
  input  logic [3:0]            wait_sel,
  output logic                  amp_cs,
  output logic                  amp_mosi,
  output logic                  ad_conv,
  output conv_pkg::adc_sample_t sample,
  output logic                  sample_valid
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_GAIN,
    S_READ,
    S_WAIT
  } state_t;

  state_t                            state;
  logic [5:0]                        bit_cnt;
  logic [7:0]                        wait_cnt;
  logic [conv_pkg::GAIN_BITS-1:0]    gain_sr;
  logic [conv_pkg::ADC_FRAME_SCK-1:0] rx_sr;
  logic [conv_pkg::ADC_FRAME_SCK-1:0] rx_next;

  assign rx_next  = {rx_sr[conv_pkg::ADC_FRAME_SCK-2:0], adc_out};
  assign amp_mosi = gain_sr[conv_pkg::GAIN_BITS-1];

  // the conversion pulse is exactly the fall strobe that ends the wait
  assign ad_conv = (state == S_WAIT) && sck_bus.fall && (wait_cnt == '0);

  always_ff @(posedge clk_50m) begin
    if (rst) begin
      state        <= S_IDLE;
      amp_cs       <= 1'b1;
      bit_cnt      <= '0;
      wait_cnt     <= '0;
      gain_sr      <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (sck_bus.fall) begin
            amp_cs  <= 1'b0;
            gain_sr <= GAIN;
            bit_cnt <= '0;
            state   <= S_GAIN;
          end
        end
        S_GAIN: begin
          if (sck_bus.rise) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (sck_bus.fall) begin
            if (bit_cnt == 6'(conv_pkg::GAIN_BITS)) begin
              amp_cs   <= 1'b1;
              wait_cnt <= '0;
              state    <= S_WAIT;
            end else begin
              gain_sr <= gain_sr << 1;
            end
          end
        end
        S_READ: begin
          if (sck_bus.rise) begin
            rx_sr   <= rx_next;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'(conv_pkg::ADC_FRAME_SCK - 1)) begin
              // bit k of the readback lands at position 34-k of the shift register
              sample.va    <= rx_next[31:18];
              sample.vb    <= rx_next[15:2];
              sample_valid <= 1'b1;
              wait_cnt     <= {wait_sel, 4'b0000};
              state        <= S_WAIT;
            end
          end
        end
        S_WAIT: begin
          if (sck_bus.fall) begin
            if (wait_cnt == '0) begin
              bit_cnt <= '0;
              state   <= S_READ;
            end else begin
              wait_cnt <= wait_cnt - 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/conv_pkg.sv
package conv_pkg;

  // spi clock level plus the one-cycle edge strobes that follow it
  typedef struct packed {
    logic sck;
    logic rise;
    logic fall;
  } spi_clk_t;

  localparam int ADC_BITS = 14;
  localparam int DAC_BITS = 12;

  typedef struct packed {
    logic [ADC_BITS-1:0] va;
    logic [ADC_BITS-1:0] vb;
  } adc_sample_t;

  // the ADC returns two channels in a 34 clock readback
  localparam int ADC_FRAME_SCK = 34;

  // dac frame is 8 don't care, command, address, 12 data and 4 don't care bits
  localparam int DAC_FRAME_BITS = 32;

  localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'b0011;
  localparam logic [3:0] DAC_ADDR_A = 4'b0000;
  localparam logic [3:0] DAC_ADDR_B = 4'b0001;

  localparam int GAIN_BITS = 8;

endpackage

// File: verilog/dac_driver.sv
module dac_driver (
  input  logic                   clk_50m,
  input  logic                   rst,
  input  conv_pkg::spi_clk_t     sck_bus,
  input  logic                   start,
  input  noise_pkg::noise_word_t noise,
  input  conv_pkg::adc_sample_t  sample,
  output logic                   dac_cs,
  output logic                   dac_clr,
  output logic                   dac_mosi
);

  typedef enum logic [1:0] {
    D_IDLE,
    D_ARM,
    D_SHIFT
  } state_t;

  state_t                              state;
  logic                                chan_b;
  logic [5:0]                          bit_cnt;
  logic [conv_pkg::DAC_BITS-1:0]       ch_a;
  logic [conv_pkg::DAC_BITS-1:0]       ch_b;
  logic [conv_pkg::DAC_FRAME_BITS-1:0] frame_sr;

  function automatic logic [conv_pkg::DAC_FRAME_BITS-1:0] build_frame(
    input logic [3:0]                    addr,
    input logic [conv_pkg::DAC_BITS-1:0] data
  );
    return {8'h00, conv_pkg::DAC_CMD_WRITE_UPDATE, addr, data, 4'h0};
  endfunction

  // the clear input is never used by this design
  assign dac_clr  = 1'b1;
  assign dac_mosi = frame_sr[conv_pkg::DAC_FRAME_BITS-1];

  always_ff @(posedge clk_50m) begin
    if (rst) begin
      state    <= D_IDLE;
      dac_cs   <= 1'b1;
      chan_b   <= 1'b0;
      bit_cnt  <= '0;
      frame_sr <= '0;
    end else begin
      case (state)
        D_IDLE: begin
          if (start) begin
            ch_a   <= noise;
            // the dac takes offset binary made from the top 12 bits of the adc sample
            ch_b   <= {~sample.va[conv_pkg::ADC_BITS-1],
                       sample.va[conv_pkg::ADC_BITS-2:conv_pkg::ADC_BITS-conv_pkg::DAC_BITS]};
            chan_b <= 1'b0;
            state  <= D_ARM;
          end
        end
        D_ARM: begin
          if (sck_bus.fall) begin
            dac_cs   <= 1'b0;
            bit_cnt  <= '0;
            frame_sr <= chan_b ? build_frame(conv_pkg::DAC_ADDR_B, ch_b)
                               : build_frame(conv_pkg::DAC_ADDR_A, ch_a);
            state    <= D_SHIFT;
          end
        end
        D_SHIFT: begin
          if (sck_bus.rise) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (sck_bus.fall) begin
            if (bit_cnt == 6'(conv_pkg::DAC_FRAME_BITS)) begin
              // cs stays high one full sck period before channel b starts
              dac_cs <= 1'b1;
              chan_b <= 1'b1;
              state  <= chan_b ? D_IDLE : D_ARM;
            end else begin
              frame_sr <= frame_sr << 1;
            end
          end
        end
        default: state <= D_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/lfsr_noise.sv
module lfsr_noise #(
  parameter int                     STEP_PERIOD = 64,
  parameter noise_pkg::lfsr_state_t LFSR_SEED   = 31'b1001001011011010111100101000100
) (
  input  logic                   clk_50m,
  input  logic                   rst,
  input  logic                   hold,
  output noise_pkg::lfsr_state_t state,
  output noise_pkg::noise_word_t noise
);

  localparam int STEP_W = (STEP_PERIOD > 1) ? $clog2(STEP_PERIOD) : 1;

  logic [STEP_W-1:0]      step_cnt;
  logic                   step;
  logic                   feedback;
  noise_pkg::noise_word_t picked;

  assign step     = (step_cnt == STEP_W'(STEP_PERIOD - 1));
  assign feedback = state[noise_pkg::TAP_HI] ~^ state[noise_pkg::TAP_LO];

  always_comb begin
    for (int i = 0; i < noise_pkg::NOISE_BITS; i++) begin
      picked[noise_pkg::NOISE_BITS-1-i] = state[noise_pkg::NOISE_PICK[i]];
    end
  end

  always_ff @(posedge clk_50m) begin
    if (rst) begin
      step_cnt <= '0;
      state    <= LFSR_SEED;
    end else if (hold) begin
      // held registers keep the seed so a run always starts from the same point
      step_cnt <= '0;
      state    <= LFSR_SEED;
    end else if (step) begin
      step_cnt <= '0;
      state    <= {state[noise_pkg::LFSR_WIDTH-2:0], feedback};
    end else begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_50m) begin
    noise <= picked;
  end

endmodule

// File: verilog/noise_pkg.sv
package noise_pkg;

  localparam int LFSR_WIDTH = 31;
  typedef logic [LFSR_WIDTH-1:0] lfsr_state_t;

  localparam int NOISE_BITS = 12;
  typedef logic [NOISE_BITS-1:0] noise_word_t;

  // new bit is the xnor of these taps and the register shifts upward
  localparam int TAP_HI = 4;
  localparam int TAP_LO = 1;

  // state bits that form the noise word, msb first
  localparam int NOISE_PICK [NOISE_BITS] = '{
    15, 12, 28, 7, 17, 21, 4, 6, 10, 21, 30, 1
  };

endpackage

// File: verilog/nyquist_top.sv
module nyquist_top #(
  parameter int                             SCK_HALF    = 2,
  parameter int                             STEP_PERIOD = 64,
  parameter noise_pkg::lfsr_state_t         LFSR_SEED   = 31'b1001001011011010111100101000100,
  parameter logic [conv_pkg::GAIN_BITS-1:0] GAIN        = 8'h11
) (
  input  logic       clk_50m,
  input  logic       rst,
  input  logic [3:0] sw,
  input  logic       adc_out,
  output logic       dac_cs,
  output logic       dac_clr,
  output logic       spi_sck,
  output logic       amp_cs,
  output logic       spi_mosi,
  output logic [7:0] led,
  output logic       ad_conv
);

  conv_pkg::spi_clk_t     sck_bus;
  conv_pkg::adc_sample_t  sample;
  noise_pkg::noise_word_t noise;
  logic                   sample_valid;
  logic                   amp_mosi;
  logic                   dac_mosi;

  assign spi_sck = sck_bus.sck;

  // the preamp owns the shared data line only while it is selected
  assign spi_mosi = amp_cs ? dac_mosi : amp_mosi;

  always_ff @(posedge clk_50m) begin
    led <= noise[7:0];
  end

  spi_clock_gen #(
    .SCK_HALF (SCK_HALF)
  ) u_sck (
    .clk_50m (clk_50m),
    .rst     (rst),
    .sck_bus (sck_bus)
  );

  lfsr_noise #(
    .STEP_PERIOD (STEP_PERIOD),
    .LFSR_SEED   (LFSR_SEED)
  ) u_noise (
    .clk_50m (clk_50m),
    .rst     (rst),
    .hold    (!sw[0]),
    .state   (),
    .noise   (noise)
  );

  adc_preamp_driver #(
    .GAIN (GAIN)
  ) u_adc (
    .clk_50m      (clk_50m),
    .rst          (rst),
    .sck_bus      (sck_bus),
    .adc_out      (adc_out),
    .wait_sel     (sw),
    .amp_cs       (amp_cs),
    .amp_mosi     (amp_mosi),
    .ad_conv      (ad_conv),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  dac_driver u_dac (
    .clk_50m  (clk_50m),
    .rst      (rst),
    .sck_bus  (sck_bus),
    .start    (sample_valid),
    .noise    (noise),
    .sample   (sample),
    .dac_cs   (dac_cs),
    .dac_clr  (dac_clr),
    .dac_mosi (dac_mosi)
  );

endmodule

// File: verilog/spi_clock_gen.sv
module spi_clock_gen #(
  parameter int SCK_HALF = 2
) (
  input  logic               clk_50m,
  input  logic               rst,
  output conv_pkg::spi_clk_t sck_bus
);

  localparam int CNT_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;

  logic [CNT_W-1:0] half_cnt;
  logic             half_done;

  assign half_done = (half_cnt == CNT_W'(SCK_HALF - 1));

  // strobes are registered with the level so they mark the cycle after the edge
  always_ff @(posedge clk_50m) begin
    if (rst) begin
      half_cnt <= '0;
      sck_bus  <= '0;
    end else begin
      sck_bus.rise <= half_done && !sck_bus.sck;
      sck_bus.fall <= half_done && sck_bus.sck;
      if (half_done) begin
        half_cnt    <= '0;
        sck_bus.sck <= !sck_bus.sck;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

endmodule
